/* build.f */
+incdir+rtl
rtl/cpu_pkg.sv
rtl/fetch_unit.sv
rtl/register_file.sv
rtl/execute_unit.sv
rtl/writeback_unit.sv
rtl/pipeline_control.sv
rtl/cpu.sv
verif/cpu_tb.sv

/* verif/cpu_tb.sv */
`timescale 1ns/1ps

module cpu_tb;
  import cpu_pkg::*;

  localparam int NUM_TESTS  = 6;
  localparam int MAX_INSTR  = 24;
  localparam int MAX_STORES = 8;

  logic  clk;
  logic  reset;
  word_t instr_addr, pc, instr_data;
  word_t mem_addr, mem_wdata, mem_rdata;
  logic  mem_en, mem_wr, hlt;

  word_t imem [256];
  word_t dmem [256];
  word_t store_addr_q [$];        // Stores seen on the data bus
  word_t store_data_q [$];

  // Program and expected stores per test
  string test_name [NUM_TESTS];
  word_t prog      [NUM_TESTS][MAX_INSTR];
  int    prog_len  [NUM_TESTS];
  word_t exp_addr  [NUM_TESTS][MAX_STORES];
  word_t exp_data  [NUM_TESTS][MAX_STORES];
  int    exp_count [NUM_TESTS];

  logic [31:0] lcg_state;
  int errors;
  int checks;
  int tests_run;

  cpu cpu_i (
    .clk(clk), .reset(reset),
    .instr_addr(instr_addr), .pc(pc), .instr_data(instr_data),
    .mem_addr(mem_addr), .mem_wdata(mem_wdata), .mem_en(mem_en), .mem_wr(mem_wr),
    .mem_rdata(mem_rdata), .hlt(hlt)
  );

  //////////////////////////////
  // Clock and memories
  //////////////////////////////
  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  assign instr_data = imem[instr_addr[8:1]];
  assign mem_rdata  = dmem[mem_addr[8:1]];

  always @(posedge clk) begin
    if (mem_en === 1'b1 && mem_wr === 1'b1) begin
      dmem[mem_addr[8:1]] <= mem_wdata;
      store_addr_q.push_back(mem_addr);
      store_data_q.push_back(mem_wdata);
    end
  end

  task automatic next_cycle();
    @(posedge clk);
    #2;                               // Drive and sample away from the edge
  endtask

  function automatic word_t rand_word();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state[31:16];
  endfunction

  //////////////////////////////
  // Instruction words and rules
  //////////////////////////////
  function automatic word_t instr_word(opcode_t op, logic [3:0] f1, logic [3:0] f2,
                                       logic [3:0] f3);
    return {op, f1, f2, f3};
  endfunction

  function automatic word_t cond_branch(cond_t cond, logic [8:0] offset);
    return {op_b, cond, offset};
  endfunction

  // Base plus twice the signed 4-bit offset
  function automatic word_t eff_addr(word_t base, logic [3:0] offset);
    int off;
    off = (offset > 7) ? int'(offset) - 16 : int'(offset);
    return base + word_t'(off * 2);
  endfunction

  function automatic word_t sra_ref(word_t value, int amount);
    word_t r;
    r = value;
    for (int i = 0; i < amount; i++) begin
      r = {r[15], r[15:1]};
    end
    return r;
  endfunction

  function automatic word_t ror_ref(word_t value, int amount);
    word_t r;
    r = value;
    for (int i = 0; i < amount; i++) begin
      r = {r[0], r[15:1]};
    end
    return r;
  endfunction

  task automatic emit(int t, word_t w);
    prog[t][prog_len[t]] = w;
    prog_len[t]++;
  endtask

  task automatic expect_store(int t, word_t addr, word_t data);
    exp_addr[t][exp_count[t]] = addr;
    exp_data[t][exp_count[t]] = data;
    exp_count[t]++;
  endtask

  // LLB then LHB on the same register
  task automatic load_const(int t, logic [3:0] rd, word_t value);
    emit(t, instr_word(op_llb, rd, value[7:4], value[3:0]));
    emit(t, instr_word(op_lhb, rd, value[15:12], value[11:8]));
  endtask

  task automatic build_table();
    word_t v1, v2, sum_w, diff_w, w;
    logic [3:0] s1, s2, s3;
    lcg_state = 32'hddafab62;
    for (int t = 0; t < NUM_TESTS; t++) begin
      prog_len[t]  = 0;
      exp_count[t] = 0;
    end

    test_name[0] = "alu_fwd";
    v1 = rand_word();
    v2 = rand_word();
    sum_w  = v1 + v2;
    diff_w = sum_w - v1;
    load_const(0, 4'd1, v1);
    load_const(0, 4'd2, v2);
    emit(0, instr_word(op_llb, 4'd14, 4'h4, 4'h0));   // Base 0x0040
    emit(0, instr_word(op_add, 4'd3, 4'd1, 4'd2));
    emit(0, instr_word(op_sub, 4'd4, 4'd3, 4'd1));    // EX to EX
    emit(0, instr_word(op_xor, 4'd5, 4'd4, 4'd3));    // Both paths
    emit(0, instr_word(op_sw, 4'd5, 4'd14, 4'd2));
    emit(0, instr_word(op_sw, 4'd4, 4'd14, 4'd1));
    emit(0, instr_word(op_sw, 4'd3, 4'd14, 4'd0));
    emit(0, instr_word(op_hlt, 4'd0, 4'd0, 4'd0));
    expect_store(0, 16'h0044, diff_w ^ sum_w);
    expect_store(0, 16'h0042, diff_w);
    expect_store(0, 16'h0040, sum_w);

    test_name[1] = "shifts";
    v1 = rand_word() | 16'h8000;                      // Negative for SRA
    w  = rand_word();
    s1 = w[3:0];
    s2 = w[7:4];
    s3 = w[11:8];
    load_const(1, 4'd1, v1);
    emit(1, instr_word(op_llb, 4'd14, 4'h5, 4'h0));
    emit(1, instr_word(op_sll, 4'd2, 4'd1, s1));
    emit(1, instr_word(op_sra, 4'd3, 4'd1, s2));
    emit(1, instr_word(op_ror, 4'd4, 4'd1, s3));
    emit(1, instr_word(op_sw, 4'd2, 4'd14, 4'd0));
    emit(1, instr_word(op_sw, 4'd3, 4'd14, 4'd1));
    emit(1, instr_word(op_sw, 4'd4, 4'd14, 4'd2));
    emit(1, instr_word(op_hlt, 4'd0, 4'd0, 4'd0));
    expect_store(1, 16'h0050, v1 << s1);
    expect_store(1, 16'h0052, sra_ref(v1, s2));
    expect_store(1, 16'h0054, ror_ref(v1, s3));

    test_name[2] = "load_store";
    v1 = rand_word();
    v2 = rand_word();
    load_const(2, 4'd1, v1);
    load_const(2, 4'd2, v2);
    emit(2, instr_word(op_llb, 4'd14, 4'h6, 4'h8));   // Negative offsets below
    emit(2, instr_word(op_sw, 4'd1, 4'd14, 4'hC));
    emit(2, instr_word(op_lw, 4'd3, 4'd14, 4'hC));
    emit(2, instr_word(op_add, 4'd4, 4'd3, 4'd2));    // Load-use
    emit(2, instr_word(op_sw, 4'd4, 4'd14, 4'hD));
    emit(2, instr_word(op_lw, 4'd5, 4'd14, 4'hD));
    emit(2, instr_word(op_sw, 4'd5, 4'd14, 4'hE));    // MEM to MEM data
    emit(2, instr_word(op_hlt, 4'd0, 4'd0, 4'd0));
    expect_store(2, eff_addr(16'h0068, 4'hC), v1);
    expect_store(2, eff_addr(16'h0068, 4'hD), v1 + v2);
    expect_store(2, eff_addr(16'h0068, 4'hE), v1 + v2);

    test_name[3] = "branch";
    v1 = rand_word();
    v2 = rand_word();
    if (v1 == v2) v2 = v2 ^ 16'h0001;
    diff_w = v1 - v2;
    load_const(3, 4'd1, v1);
    load_const(3, 4'd2, v2);
    emit(3, instr_word(op_llb, 4'd14, 4'h7, 4'h0));
    emit(3, instr_word(op_sub, 4'd3, 4'd1, 4'd1));    // Z set
    emit(3, cond_branch(3'd0, 9'd1));                 // Not equal
    emit(3, instr_word(op_sw, 4'd1, 4'd14, 4'd0));
    emit(3, instr_word(op_sub, 4'd3, 4'd1, 4'd2));
    emit(3, cond_branch(3'd2, 9'd1));                 // Greater
    emit(3, instr_word(op_sw, 4'd2, 4'd14, 4'd1));
    emit(3, instr_word(op_sw, 4'd3, 4'd14, 4'd2));
    emit(3, cond_branch(3'd7, 9'd1));                 // Always
    emit(3, instr_word(op_sw, 4'd1, 4'd14, 4'd3));
    emit(3, instr_word(op_sw, 4'd2, 4'd14, 4'd4));
    emit(3, instr_word(op_hlt, 4'd0, 4'd0, 4'd0));
    expect_store(3, 16'h0070, v1);
    // Greater means not zero and not negative
    if (diff_w == 16'h0000 || diff_w[15]) expect_store(3, 16'h0072, v2);
    expect_store(3, 16'h0074, diff_w);
    expect_store(3, 16'h0078, v2);

    test_name[4] = "br_pcs";
    emit(4, instr_word(op_llb, 4'd14, 4'h8, 4'h0));
    emit(4, instr_word(op_pcs, 4'd1, 4'd0, 4'd0));
    emit(4, instr_word(op_sw, 4'd1, 4'd14, 4'd0));
    emit(4, instr_word(op_llb, 4'd2, 4'h0, 4'hE));    // Address of word 7
    emit(4, instr_word(op_br, {3'd7, 1'b0}, 4'd2, 4'd0));
    emit(4, instr_word(op_sw, 4'd14, 4'd14, 4'd1));
    emit(4, instr_word(op_sw, 4'd14, 4'd14, 4'd2));
    emit(4, instr_word(op_pcs, 4'd3, 4'd0, 4'd0));
    emit(4, instr_word(op_sw, 4'd3, 4'd14, 4'd3));
    emit(4, instr_word(op_hlt, 4'd0, 4'd0, 4'd0));
    expect_store(4, 16'h0080, 16'd2 * 1 + 16'd2);     // PCS address plus 2
    expect_store(4, 16'h0086, 16'd2 * 7 + 16'd2);

    test_name[5] = "halt";
    v1 = rand_word();
    emit(5, instr_word(op_llb, 4'd14, 4'h9, 4'h0));
    load_const(5, 4'd1, v1);
    emit(5, instr_word(op_sw, 4'd1, 4'd14, 4'd0));
    emit(5, instr_word(op_hlt, 4'd0, 4'd0, 4'd0));
    emit(5, instr_word(op_sw, 4'd1, 4'd14, 4'd1));
    emit(5, instr_word(op_sw, 4'd1, 4'd14, 4'd2));
    expect_store(5, 16'h0090, v1);
  endtask

  //////////////////////////////
  // Checks and test run
  //////////////////////////////
  task automatic check_value(string name, word_t got, word_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic run_test(int t, output logic timed_out);
    int    errors_before;
    int    cycles;
    word_t held_pc;
    errors_before = errors;
    timed_out = 1'b0;
    reset = 1'b1;
    for (int i = 0; i < 256; i++) begin
      imem[i] = {4'h3, 4'h0, i[7:0]};                 // No-op fill
      dmem[i] = word_t'(i * 32'h9e37) ^ 16'h5a5a;
    end
    for (int i = 0; i < prog_len[t]; i++) begin
      imem[i] = prog[t][i];
    end
    repeat (16) next_cycle();
    store_addr_q.delete();
    store_data_q.delete();
    reset = 1'b0;
    check_value("pc", pc, 16'h0000);
    check_value("hlt", {15'h0000, hlt}, 16'h0000);
    check_value("mem_en", {15'h0000, mem_en}, 16'h0000);
    check_value("mem_wr", {15'h0000, mem_wr}, 16'h0000);

    cycles = 0;
    while (hlt !== 1'b1 && cycles < 400) begin
      next_cycle();
      cycles++;
    end
    if (hlt !== 1'b1) begin
      $display("Timeout: hlt did not rise within 400 cycles in test %0d", t);
      errors++;
      timed_out = 1'b1;
    end else begin
      held_pc = pc;
      repeat (10) begin                              // PC frozen while the pipeline drains
        next_cycle();
        check_value("pc", pc, held_pc);
        check_value("instr_addr", instr_addr, held_pc);
        check_value("hlt", {15'h0000, hlt}, 16'h0001);
      end
      check_value("store count", word_t'(store_addr_q.size()), word_t'(exp_count[t]));
      for (int j = 0; j < exp_count[t] && j < store_addr_q.size(); j++) begin
        check_value("mem_addr", store_addr_q[j], exp_addr[t][j]);
        check_value("mem_wdata", store_data_q[j], exp_data[t][j]);
      end
      $display("Test %0d %-10s %0d stores, %s", t, test_name[t], store_addr_q.size(),
               (errors == errors_before) ? "ok" : "FAILED");
    end
  endtask

  initial begin
    logic timed_out;
    reset     = 1'b1;
    errors    = 0;
    checks    = 0;
    tests_run = 0;
    timed_out = 1'b0;
    build_table();
    for (int t = 0; t < NUM_TESTS && !timed_out; t++) begin
      run_test(t, timed_out);
      tests_run++;
    end
    $display("Tests run %0d of %0d, checks %0d, errors %0d", tests_run, NUM_TESTS,
             checks, errors);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

/* rtl/cpu.sv */
`timescale 1ns/1ps

module cpu (
  input  logic           clk,
  input  logic           reset,
  output cpu_pkg::word_t instr_addr,
  output cpu_pkg::word_t pc,
  input  cpu_pkg::word_t instr_data,
  output cpu_pkg::word_t mem_addr,
  output cpu_pkg::word_t mem_wdata,
  output logic           mem_en,
  output logic           mem_wr,
  input  cpu_pkg::word_t mem_rdata,
  output logic           hlt
);
  import cpu_pkg::*;

  // Fetch / decode
  word_t    if_id_instr;
  word_t    if_id_pc_plus2;
  logic     take_branch;
  logic     pc_stall;
  logic     if_id_flush;
  logic     stall;

  // Register file
  reg_idx_t rd_idx_a;
  reg_idx_t rd_idx_b;
  word_t    rd_data_a;
  word_t    rd_data_b;

  // Execute
  logic     id_ex_clear;
  word_t    imm_sel;
  opcode_t  alu_op;
  fwd_sel_t fwd_a;
  fwd_sel_t fwd_b;
  logic     store_fwd;
  flags_t   flags;
  word_t    alu_result;
  word_t    store_data;

  // Writeback
  logic     wb_en;
  logic     wb_from_mem;
  reg_idx_t wb_idx;
  word_t    wb_data;

  assign instr_addr = pc;
  assign mem_addr   = alu_result;
  assign mem_wdata  = store_data;

  pipeline_control ctrl_i (
    .clk(clk), .reset(reset),
    .if_id_instr(if_id_instr), .if_id_pc_plus2(if_id_pc_plus2),
    .flags(flags),
    .rd_idx_a(rd_idx_a), .rd_idx_b(rd_idx_b),
    .take_branch(take_branch), .pc_stall(pc_stall), .if_id_flush(if_id_flush),
    .stall(stall), .id_ex_clear(id_ex_clear),
    .imm_sel(imm_sel), .alu_op(alu_op), .fwd_a(fwd_a), .fwd_b(fwd_b),
    .store_fwd(store_fwd), .mem_en(mem_en), .mem_wr(mem_wr),
    .wb_en(wb_en), .wb_from_mem(wb_from_mem), .wb_idx(wb_idx),
    .hlt(hlt)
  );

  // BR jumps to the register value, B adds imm_sel to PC+2
  fetch_unit fetch_i (
    .clk(clk), .reset(reset),
    .pc_stall(pc_stall), .if_id_flush(if_id_flush), .stall(stall),
    .take_branch(take_branch),
    .branch_base(rd_data_a), .branch_offset(imm_sel),
    .instr_data(instr_data),
    .pc(pc), .if_id_instr(if_id_instr), .if_id_pc_plus2(if_id_pc_plus2)
  );

  register_file regs_i (
    .clk(clk), .reset(reset),
    .rd_idx_a(rd_idx_a), .rd_idx_b(rd_idx_b), .wr_idx(wb_idx),
    .wr_en(wb_en), .wr_data(wb_data),
    .rd_data_a(rd_data_a), .rd_data_b(rd_data_b)
  );

  execute_unit exec_i (
    .clk(clk), .reset(reset), .stall(stall), .id_ex_clear(id_ex_clear),
    .rd_data_a(rd_data_a), .rd_data_b(rd_data_b), .imm_sel(imm_sel),
    .wb_data(wb_data), .alu_op(alu_op), .fwd_a(fwd_a), .fwd_b(fwd_b),
    .store_fwd(store_fwd),
    .flags(flags), .alu_result(alu_result), .store_data(store_data)
  );

  writeback_unit wb_i (
    .clk(clk), .reset(reset), .wb_from_mem(wb_from_mem),
    .alu_result(alu_result), .mem_rdata(mem_rdata),
    .wb_data(wb_data)
  );

endmodule

/* rtl/pipeline_control.sv */
`timescale 1ns/1ps
`include "cpu_defs.svh"

module pipeline_control (
  input  logic              clk,
  input  logic              reset,
  input  cpu_pkg::word_t    if_id_instr,
  input  cpu_pkg::word_t    if_id_pc_plus2,
  input  cpu_pkg::flags_t   flags,
  output cpu_pkg::reg_idx_t rd_idx_a,
  output cpu_pkg::reg_idx_t rd_idx_b,
  output logic              take_branch,
  output logic              pc_stall,
  output logic              if_id_flush,
  output logic              stall,
  output logic              id_ex_clear,
  output cpu_pkg::word_t    imm_sel,
  output cpu_pkg::opcode_t  alu_op,
  output cpu_pkg::fwd_sel_t fwd_a,
  output cpu_pkg::fwd_sel_t fwd_b,
  output logic              store_fwd,
  output logic              mem_en,
  output logic              mem_wr,
  output logic              wb_en,
  output logic              wb_from_mem,
  output cpu_pkg::reg_idx_t wb_idx,
  output logic              hlt
);
  import cpu_pkg::*;

  logic [3:0] opc;
  reg_idx_t   rd, rs, rt;
  cond_t      cond;
  logic is_alu3, is_shift, is_lw, is_sw, is_llb, is_lhb, is_b, is_br, is_pcs, is_hlt;
  logic dec_wb_en, uses_a, uses_b;
  logic load_use, br_hazard, branch_stall, branch_wait_q, cond_met;
  logic     id_ex_wb_en, id_ex_from_mem, id_ex_mem_en, id_ex_mem_wr;
  reg_idx_t id_ex_dst, id_ex_src_a, id_ex_src_b;
  logic     ex_mem_wb_en, ex_mem_from_mem;
  reg_idx_t ex_mem_dst, ex_mem_src_b;

  ////////////////////////////////
  // Decode
  ////////////////////////////////
  assign opc  = if_id_instr[`CPU_OPC_MSB:`CPU_OPC_LSB];
  assign rd   = if_id_instr[11:8];
  assign rs   = if_id_instr[7:4];
  assign rt   = if_id_instr[3:0];
  assign cond = if_id_instr[`CPU_COND_MSB:`CPU_COND_LSB];

  assign is_alu3  = (opc <= 4'h2);
  assign is_shift = (opc >= 4'h4) && (opc <= 4'h6);
  assign is_lw    = (opc == op_lw);
  assign is_sw    = (opc == op_sw);
  assign is_llb   = (opc == op_llb);
  assign is_lhb   = (opc == op_lhb);
  assign is_b     = (opc == op_b);
  assign is_br    = (opc == op_br);
  assign is_pcs   = (opc == op_pcs);
  assign is_hlt   = (opc == op_hlt);

  assign rd_idx_a  = (is_llb || is_lhb) ? rd : rs; // LLB/LHB merge into rd
  assign rd_idx_b  = is_sw ? rd : rt;              // SW stores rd field
  assign dec_wb_en = is_alu3 | is_shift | is_lw | is_llb | is_lhb | is_pcs;
  assign uses_a    = is_alu3 | is_shift | is_lw | is_sw | is_llb | is_lhb;
  assign uses_b    = is_alu3;

  always_comb begin
    imm_sel = '0;
    if (is_shift) imm_sel = {12'h000, if_id_instr[3:0]};
    else if (is_lw || is_sw) imm_sel = {{11{if_id_instr[3]}}, if_id_instr[3:0], 1'b0};
    else if (is_llb || is_lhb) imm_sel = {8'h00, if_id_instr[7:0]};
    else if (is_b) imm_sel = {{6{if_id_instr[8]}}, if_id_instr[8:0], 1'b0};
    else if (is_pcs) imm_sel = if_id_pc_plus2;
  end

  ////////////////////////////////
  // Hazards and branches
  ////////////////////////////////
  assign load_use = id_ex_from_mem && (id_ex_dst != '0) &&
                    ((uses_a && id_ex_dst == rd_idx_a) || (uses_b && id_ex_dst == rd_idx_b));

  // BR target must be in the register file before it is used
  assign br_hazard = is_br && (rs != '0) &&
                     ((id_ex_wb_en && id_ex_dst == rs) || (ex_mem_wb_en && ex_mem_dst == rs));

  assign branch_stall = (is_b || is_br) && (!branch_wait_q || br_hazard);

  always_comb begin
    case (cond)
      3'd0:    cond_met = !flags[2];
      3'd1:    cond_met = flags[2];
      3'd2:    cond_met = !flags[2] && !flags[0];
      3'd3:    cond_met = flags[0];
      3'd4:    cond_met = flags[2] || !flags[0];
      3'd5:    cond_met = flags[0] || flags[2];
      3'd6:    cond_met = flags[1];
      default: cond_met = 1'b1;
    endcase
  end

  assign stall       = !hlt && (load_use || branch_stall);
  assign pc_stall    = stall || hlt;
  assign take_branch = !hlt && (is_b || is_br) && !branch_stall && cond_met;
  assign if_id_flush = take_branch;       // Drop the fall-through
  assign id_ex_clear = hlt || is_hlt;

  always_ff @(posedge clk) begin
    if (reset) begin
      branch_wait_q <= 1'b0;
      hlt           <= 1'b0;
    end else begin
      branch_wait_q <= stall && branch_stall;
      if (is_hlt) hlt <= 1'b1; // Sticky until reset
    end
  end

  ////////////////////////////////
  // Pipelined control bits
  ////////////////////////////////
  always_ff @(posedge clk) begin
    if (reset || stall || id_ex_clear) begin
      id_ex_wb_en <= 1'b0;
      id_ex_from_mem <= 1'b0;
      id_ex_mem_en <= 1'b0;
      id_ex_mem_wr <= 1'b0;
      id_ex_dst <= '0;
      id_ex_src_a <= '0;
      id_ex_src_b <= '0;
      alu_op <= op_b;                     // No ALU or flag effect
    end else begin
      id_ex_wb_en <= dec_wb_en;
      id_ex_from_mem <= is_lw;
      id_ex_mem_en <= is_lw | is_sw;
      id_ex_mem_wr <= is_sw;
      id_ex_dst <= rd;
      id_ex_src_a <= rd_idx_a;
      id_ex_src_b <= rd_idx_b;
      alu_op <= (is_alu3 || is_shift || is_lw || is_sw || is_llb || is_lhb || is_pcs) ?
                opcode_t'(opc) : op_b;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      ex_mem_wb_en <= 1'b0;
      ex_mem_from_mem <= 1'b0;
      mem_en <= 1'b0;
      mem_wr <= 1'b0;
      ex_mem_dst <= '0;
      ex_mem_src_b <= '0;
      wb_en <= 1'b0;
      wb_from_mem <= 1'b0;
      wb_idx <= '0;
    end else begin
      ex_mem_wb_en <= id_ex_wb_en;
      ex_mem_from_mem <= id_ex_from_mem;
      mem_en <= id_ex_mem_en;
      mem_wr <= id_ex_mem_wr;
      ex_mem_dst <= id_ex_dst;
      ex_mem_src_b <= id_ex_src_b;
      wb_en <= ex_mem_wb_en;
      wb_from_mem <= ex_mem_from_mem;
      wb_idx <= ex_mem_dst;
    end
  end

  // Forwarding, load data in EX/MEM is not ready yet
  always_comb begin
    fwd_a = fwd_none;
    fwd_b = fwd_none;
    if (ex_mem_wb_en && !ex_mem_from_mem && ex_mem_dst != '0 && ex_mem_dst == id_ex_src_a)
      fwd_a = fwd_ex_mem;
    else if (wb_en && wb_idx != '0 && wb_idx == id_ex_src_a)
      fwd_a = fwd_mem_wb;
    if (ex_mem_wb_en && !ex_mem_from_mem && ex_mem_dst != '0 && ex_mem_dst == id_ex_src_b)
      fwd_b = fwd_ex_mem;
    else if (wb_en && wb_idx != '0 && wb_idx == id_ex_src_b)
      fwd_b = fwd_mem_wb;
  end

  assign store_fwd = mem_wr && wb_en && (wb_idx != '0) && (wb_idx == ex_mem_src_b);

endmodule

/* rtl/writeback_unit.sv */
`timescale 1ns/1ps

module writeback_unit (
  input  logic           clk,
  input  logic           reset,
  input  logic           wb_from_mem,
  input  cpu_pkg::word_t alu_result,
  input  cpu_pkg::word_t mem_rdata,
  output cpu_pkg::word_t wb_data
);
  import cpu_pkg::*;

  word_t load_q;
  word_t alu_q;

  // MEM/WB data
  always_ff @(posedge clk) begin
    if (reset) begin
      load_q <= '0;
      alu_q  <= '0;
    end else begin
      load_q <= mem_rdata;
      alu_q  <= alu_result;
    end
  end

  assign wb_data = wb_from_mem ? load_q : alu_q; // Load data or ALU result

endmodule

/* rtl/execute_unit.sv */
`timescale 1ns/1ps

module execute_unit (
  input  logic              clk,
  input  logic              reset,
  input  logic              stall,
  input  logic              id_ex_clear,
  input  cpu_pkg::word_t    rd_data_a,
  input  cpu_pkg::word_t    rd_data_b,
  input  cpu_pkg::word_t    imm_sel,
  input  cpu_pkg::word_t    wb_data,
  input  cpu_pkg::opcode_t  alu_op,
  input  cpu_pkg::fwd_sel_t fwd_a,
  input  cpu_pkg::fwd_sel_t fwd_b,
  input  logic              store_fwd,
  output cpu_pkg::flags_t   flags,
  output cpu_pkg::word_t    alu_result,
  output cpu_pkg::word_t    store_data
);
  import cpu_pkg::*;

  word_t  opa_q, opb_q, imm_q;  // ID/EX data
  word_t  a, b, alu_out;
  word_t  store_q;
  logic [31:0] rot;
  flags_t flags_next;

  always_ff @(posedge clk) begin
    if (id_ex_clear) begin
      opa_q <= '0;
      opb_q <= '0;
      imm_q <= '0;
    end else if (!stall) begin
      opa_q <= rd_data_a;
      opb_q <= rd_data_b;
      imm_q <= imm_sel;
    end
  end

  assign a = (fwd_a == fwd_ex_mem) ? alu_result : (fwd_a == fwd_mem_wb) ? wb_data : opa_q;
  assign b = (fwd_b == fwd_ex_mem) ? alu_result : (fwd_b == fwd_mem_wb) ? wb_data : opb_q;
  assign rot = {a, a} >> imm_q[3:0];

  ////////////////////////////////
  // ALU and flags
  ////////////////////////////////
  always_comb begin
    alu_out    = '0;
    flags_next = flags;
    case (alu_op)
      op_add: begin
        alu_out    = a + b;
        flags_next = {alu_out == '0, (a[15] == b[15]) && (alu_out[15] != a[15]), alu_out[15]};
      end
      op_sub: begin
        alu_out    = a - b;
        flags_next = {alu_out == '0, (a[15] != b[15]) && (alu_out[15] != a[15]), alu_out[15]};
      end
      op_xor: alu_out = a ^ b;
      op_sll: alu_out = a << imm_q[3:0];
      op_sra: alu_out = $signed(a) >>> imm_q[3:0];
      op_ror: alu_out = rot[15:0];
      op_llb: alu_out = {a[15:8], imm_q[7:0]};
      op_lhb: alu_out = {imm_q[7:0], a[7:0]};
      op_lw, op_sw: alu_out = a + imm_q; // Base plus offset
      op_pcs: alu_out = imm_q;
      default: alu_out = '0;
    endcase
    if (alu_op == op_xor || alu_op == op_sll || alu_op == op_sra || alu_op == op_ror)
      flags_next[2] = (alu_out == '0);   // Z only
  end

  always_ff @(posedge clk) begin
    if (reset) flags <= '0;
    else flags <= flags_next;
  end

  // EX/MEM data
  always_ff @(posedge clk) begin
    alu_result <= alu_out;
    store_q    <= b;
  end

  assign store_data = store_fwd ? wb_data : store_q; // MEM to MEM path

endmodule

/* rtl/register_file.sv */
`timescale 1ns/1ps
`include "cpu_defs.svh"

module register_file (
  input  logic              clk,
  input  logic              reset,
  input  cpu_pkg::reg_idx_t rd_idx_a,
  input  cpu_pkg::reg_idx_t rd_idx_b,
  input  cpu_pkg::reg_idx_t wr_idx,
  input  logic              wr_en,
  input  cpu_pkg::word_t    wr_data,
  output cpu_pkg::word_t    rd_data_a,
  output cpu_pkg::word_t    rd_data_b
);
  import cpu_pkg::*;

  word_t regs [`CPU_NUM_REGS];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < `CPU_NUM_REGS; i++) regs[i] <= '0;
    end else if (wr_en && wr_idx != '0) begin
      regs[wr_idx] <= wr_data;
    end
  end

  // Write data bypasses to a same-cycle read
  assign rd_data_a = (rd_idx_a == '0) ? '0 :
                     (wr_en && wr_idx == rd_idx_a) ? wr_data : regs[rd_idx_a];
  assign rd_data_b = (rd_idx_b == '0) ? '0 :
                     (wr_en && wr_idx == rd_idx_b) ? wr_data : regs[rd_idx_b];

endmodule

/* rtl/fetch_unit.sv */
`timescale 1ns/1ps
`include "cpu_defs.svh"

module fetch_unit (
  input  logic           clk,
  input  logic           reset,
  input  logic           pc_stall,
  input  logic           if_id_flush,
  input  logic           stall,
  input  logic           take_branch,
  input  cpu_pkg::word_t branch_base,
  input  cpu_pkg::word_t branch_offset,
  input  cpu_pkg::word_t instr_data,
  output cpu_pkg::word_t pc,
  output cpu_pkg::word_t if_id_instr,
  output cpu_pkg::word_t if_id_pc_plus2
);
  import cpu_pkg::*;

  word_t pc_plus2;
  word_t target;
  logic  is_br;

  assign pc_plus2 = pc + 16'd2;
  assign is_br    = if_id_instr[`CPU_OPC_LSB]; // D vs C
  assign target   = (is_br ? 16'h0000 : if_id_pc_plus2) + (is_br ? branch_base : branch_offset);

  always_ff @(posedge clk) begin
    if (reset) pc <= `CPU_RESET_PC;
    else if (take_branch) pc <= target;
    else if (!pc_stall) pc <= pc_plus2;
  end

  // IF/ID register
  always_ff @(posedge clk) begin
    if (reset || if_id_flush) begin
      if_id_instr    <= `CPU_NOP_INSTR;
      if_id_pc_plus2 <= '0;
    end else if (!stall) begin
      if_id_instr    <= instr_data;
      if_id_pc_plus2 <= pc_plus2;
    end
  end

endmodule

/* rtl/cpu_pkg.sv */
package cpu_pkg;

  typedef logic [15:0] word_t;    // Data and address word
  typedef logic [3:0]  reg_idx_t; // Register number
  typedef logic [2:0]  flags_t;   // {Z, V, N}
  typedef logic [2:0]  cond_t;    // Branch condition code

  // Opcodes 3 and 7 are reserved
  typedef enum logic [3:0] {
    op_add = 4'h0,
    op_sub = 4'h1,
    op_xor = 4'h2,
    op_sll = 4'h4,
    op_sra = 4'h5,
    op_ror = 4'h6,
    op_lw  = 4'h8,
    op_sw  = 4'h9,
    op_llb = 4'hA,
    op_lhb = 4'hB,
    op_b   = 4'hC,
    op_br  = 4'hD,
    op_pcs = 4'hE,
    op_hlt = 4'hF
  } opcode_t;

  // Operand source in EX
  typedef enum logic [1:0] {
    fwd_none   = 2'd0,
    fwd_ex_mem = 2'd1,
    fwd_mem_wb = 2'd2
  } fwd_sel_t;

endpackage

/* rtl/cpu_defs.svh */
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

// Register file size, register 0 is hardwired to zero
`define CPU_NUM_REGS   16

// Address of the first instruction after reset
`define CPU_RESET_PC   16'h0000

// Opcode field in the instruction word
`define CPU_OPC_MSB    15
`define CPU_OPC_LSB    12

// Branch condition field
`define CPU_COND_MSB   11
`define CPU_COND_LSB   9

// Reserved opcode 3, decodes as a no-op
`define CPU_NOP_INSTR  16'h3000

`endif
